// ==== flist.f ====
rtl/load_pkg.sv
rtl/load_rs.sv
rtl/load_mem_ctrl.sv
rtl/mem_latency_timer.sv
rtl/load_align.sv
rtl/load_unit_top.sv
bench/load_unit_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := load_unit_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TEST FAIL" $(LOG) || [ $$status -ne 0 ]; then \
	  echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/load_unit_tb.sv ====
module load_unit_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_tags = 1 << load_pkg::rob_tag_w;
  localparam int n_random = 40;
  localparam int n_flush = 3;
  localparam int n_full = 4;
  localparam int watchdog_cycles =
    (n_random + n_flush + n_full) * (load_pkg::mem_latency + 8) + 16 + 200;

  logic clk;
  logic rst_n;
  logic flush;
  logic issue_valid;
  load_pkg::load_funct_e issue_funct3;
  logic [31:0] issue_imm;
  logic [load_pkg::rob_tag_w-1:0] issue_rob;
  logic issue_rs1_ready;
  logic [31:0] issue_rs1_v;
  logic [load_pkg::rob_tag_w-1:0] issue_rs1_rob;
  logic rs_full;
  logic cdb_valid [load_pkg::cdb_ports];
  logic [load_pkg::rob_tag_w-1:0] cdb_rob [load_pkg::cdb_ports];
  logic [31:0] cdb_v [load_pkg::cdb_ports];
  logic dmem_rd;
  logic [31:0] dmem_addr;
  logic [3:0] dmem_rmask;
  logic [31:0] dmem_rdata = '0;
  logic res_valid;
  logic [load_pkg::rob_tag_w-1:0] res_rob;
  logic [31:0] res_v;
  logic [31:0] res_addr;
  logic [3:0] res_rmask;

  // reference state, indexed by rob tag
  logic [n_tags-1:0] in_flight;
  logic [n_tags-1:0] ready_tags;
  logic [n_tags-1:0] rd_ready_snap;
  logic [31:0] exp_rs1 [n_tags];
  logic [31:0] exp_imm [n_tags];
  load_pkg::load_funct_e exp_kind [n_tags];
  logic rd_busy;
  int unsigned rd_age;
  logic [31:0] rd_addr;
  logic [3:0] rd_rmask;
  logic first_cycle;

  logic [31:0] lfsr_q;
  logic [31:0] addr_pipe [load_pkg::mem_latency-1] = '{default: '0};
  logic rd_pipe [load_pkg::mem_latency-1] = '{default: 1'b0};

  load_unit_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(watchdog_cycles * 10);
    $display("Error at %0d ns: watchdog expired before the test finished", $time);
    stop_with_failure();
  end

  task automatic stop_with_failure();
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    stop_with_failure();
  endtask

  task automatic report_error(input string what);
    $display("Error at %0d ns: %s", $time, what);
    stop_with_failure();
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // memory contents as a pattern of the word address
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return {2'b00, addr[31:2]} ^ 32'h9e37_79b9;
  endfunction

  function automatic logic [31:0] expect_value(input load_pkg::load_funct_e kind,
                                               input logic [31:0] addr);
    logic [31:0] word;
    logic [7:0] b;
    logic [15:0] h;
    word = mem_word(addr);
    case (addr[1:0])
      2'd0: b = word[7:0];
      2'd1: b = word[15:8];
      2'd2: b = word[23:16];
      default: b = word[31:24];
    endcase
    h = addr[1] ? word[31:16] : word[15:0];
    case (kind)
      load_pkg::lb: return {{24{b[7]}}, b};
      load_pkg::lbu: return {24'h0, b};
      load_pkg::lh: return {{16{h[15]}}, h};
      load_pkg::lhu: return {16'h0, h};
      default: return word;
    endcase
  endfunction

  function automatic logic [3:0] expect_mask(input load_pkg::load_funct_e kind,
                                             input logic [1:0] off);
    logic [3:0] mask;
    mask = '0;
    case (kind)
      load_pkg::lb, load_pkg::lbu: mask[off] = 1'b1;
      load_pkg::lh, load_pkg::lhu: begin
        mask[off] = 1'b1;
        if (off != 2'd3) mask[off + 2'd1] = 1'b1;
      end
      default: mask = 4'hf;
    endcase
    return mask;
  endfunction

  function automatic load_pkg::load_funct_e kind_of(input logic [31:0] sel);
    case (sel % 5)
      0: return load_pkg::lb;
      1: return load_pkg::lh;
      2: return load_pkg::lw;
      3: return load_pkg::lbu;
      default: return load_pkg::lhu;
    endcase
  endfunction

  // read data valid exactly mem_latency cycles after the strobe cycle
  always @(posedge clk) begin
    rd_pipe[0] <= dmem_rd;
    addr_pipe[0] <= dmem_addr;
    for (int k = 1; k < load_pkg::mem_latency - 1; k++) begin
      rd_pipe[k] <= rd_pipe[k-1];
      addr_pipe[k] <= addr_pipe[k-1];
    end
    dmem_rdata <= rd_pipe[load_pkg::mem_latency-2] ?
                  mem_word(addr_pipe[load_pkg::mem_latency-2]) : 32'h0;
  end

  task automatic check_result();
    logic [31:0] exp_addr;
    exp_addr = exp_rs1[res_rob] + exp_imm[res_rob];
    assert (in_flight[res_rob]) else report_error("result for a ROB tag not in flight");
    assert (rd_ready_snap[res_rob])
      else report_error("memory read issued before the operand was broadcast");
    assert (res_addr == exp_addr) else report_mismatch("res_addr", res_addr, exp_addr);
    assert (res_addr == rd_addr) else report_mismatch("res_addr vs dmem_addr", res_addr, rd_addr);
    assert (rd_rmask == expect_mask(exp_kind[res_rob], res_addr[1:0]))
      else report_mismatch("dmem_rmask", 32'(rd_rmask),
                           32'(expect_mask(exp_kind[res_rob], res_addr[1:0])));
    assert (res_v == expect_value(exp_kind[res_rob], res_addr))
      else report_mismatch("res_v", res_v, expect_value(exp_kind[res_rob], res_addr));
    assert (res_rmask == expect_mask(exp_kind[res_rob], res_addr[1:0]))
      else report_mismatch("res_rmask", 32'(res_rmask),
                           32'(expect_mask(exp_kind[res_rob], res_addr[1:0])));
  endtask

  always @(posedge clk) begin
    logic full_exp;
    logic [2:0] tg;
    if (!rst_n) begin
      in_flight = '0;
      ready_tags = '0;
      rd_busy = 1'b0;
      rd_age = 0;
      first_cycle = 1'b1;
    end else begin
      if (first_cycle) begin
        assert (!dmem_rd && !res_valid && !rs_full)
          else report_error("outputs not idle after reset");
      end
      first_cycle = 1'b0;
      full_exp = ($countones(in_flight) == load_pkg::rs_entries);
      assert (rs_full == full_exp) else report_mismatch("rs_full", 32'(rs_full), 32'(full_exp));
      if (flush) begin
        assert (!res_valid && !dmem_rd) else report_error("memory activity during flush");
        in_flight = '0;
        ready_tags = '0;
        rd_busy = 1'b0;
      end else begin
        if (rd_busy) begin
          rd_age = rd_age + 1;
          assert (!dmem_rd) else report_error("second read before the result of the first");
          if (res_valid) begin
            assert (rd_age == load_pkg::mem_latency)
              else report_mismatch("read latency", 32'(rd_age), 32'(load_pkg::mem_latency));
          end else begin
            assert (rd_age < load_pkg::mem_latency)
              else report_error("no result after the memory latency");
          end
        end else begin
          assert (!res_valid) else report_error("result without a memory read");
        end
        if (res_valid) begin
          check_result();
          in_flight[res_rob] = 1'b0;
          ready_tags[res_rob] = 1'b0;
          rd_busy = 1'b0;
        end
        if (dmem_rd) begin
          assert ((in_flight & ready_tags) != '0)
            else report_error("memory read with no ready load in the station");
          rd_busy = 1'b1;
          rd_age = 0;
          rd_addr = dmem_addr;
          rd_rmask = dmem_rmask;
          rd_ready_snap = ready_tags;
        end
        for (int p = 0; p < load_pkg::cdb_ports; p++) begin
          for (int t = 0; t < n_tags; t++) begin
            tg = 3'(t);
            if (cdb_valid[p] && in_flight[tg] && !ready_tags[tg] &&
                (tg ^ 3'b100) == cdb_rob[p]) begin
              exp_rs1[tg] = cdb_v[p];
              ready_tags[tg] = 1'b1;
            end
          end
        end
        if (issue_valid) begin
          in_flight[issue_rob] = 1'b1;
          ready_tags[issue_rob] = issue_rs1_ready;
          exp_kind[issue_rob] = issue_funct3;
          exp_imm[issue_rob] = issue_imm;
          exp_rs1[issue_rob] = issue_rs1_v;
        end
      end
    end
  end

  task automatic clear_strobes();
    issue_valid <= 1'b0;
    for (int p = 0; p < load_pkg::cdb_ports; p++) begin
      cdb_valid[p] <= 1'b0;
    end
  endtask

  task automatic pick_held(output logic [2:0] tag, output logic found);
    logic [31:0] bits;
    logic [2:0] cand;
    found = 1'b0;
    tag = '0;
    bits = rand_bits(3);
    for (int k = 0; k < n_tags; k++) begin
      cand = bits[2:0] + 3'(k);
      if (!found && in_flight[cand] && !ready_tags[cand]) begin
        tag = cand;
        found = 1'b1;
      end
    end
  endtask

  // operand producer of a load is its tag with the top bit flipped
  task automatic drive_release(input logic [2:0] tag);
    logic [31:0] bits;
    logic [31:0] val;
    bits = rand_bits(1);
    val = rand_bits(30);
    cdb_valid[bits[0]] <= 1'b1;
    cdb_rob[bits[0]] <= tag ^ 3'b100;
    cdb_v[bits[0]] <= {val[29:0], 2'b00};
  endtask

  task automatic release_cycle();
    logic [2:0] tag;
    logic found;
    pick_held(tag, found);
    @(posedge clk);
    if (found) drive_release(tag);
    @(posedge clk);
    clear_strobes();
  endtask

  // mode 0 ready operand, 1 held operand, 2 random with cdb releases
  task automatic issue_load(input int mode);
    logic [2:0] tag;
    logic [2:0] rel_tag;
    logic rel_found;
    logic hold;
    logic [1:0] off;
    logic [31:0] bits;
    load_pkg::load_funct_e kind;
    @(negedge clk);
    while (rs_full) begin
      release_cycle();
      @(negedge clk);
    end
    bits = rand_bits(3);
    tag = bits[2:0];
    while (in_flight[tag]) tag = tag + 3'd1;
    kind = kind_of(rand_bits(3));
    bits = rand_bits(2);
    case (kind)
      load_pkg::lw: off = 2'd0;
      load_pkg::lh, load_pkg::lhu: off = {bits[1], 1'b0};
      default: off = bits[1:0];
    endcase
    bits = rand_bits(1);
    hold = (mode == 1) || (mode == 2 && bits[0]);
    rel_found = 1'b0;
    bits = rand_bits(1);
    if (mode == 2 && bits[0]) pick_held(rel_tag, rel_found);
    @(posedge clk);
    issue_valid <= 1'b1;
    issue_funct3 <= kind;
    issue_rob <= tag;
    issue_rs1_rob <= tag ^ 3'b100;
    issue_rs1_ready <= !hold;
    bits = rand_bits(10);
    issue_imm <= {{20{bits[9]}}, bits[9:0], off};
    bits = rand_bits(30);
    issue_rs1_v <= {bits[29:0], 2'b00};
    if (rel_found) drive_release(rel_tag);
    @(posedge clk);
    clear_strobes();
  endtask

  task automatic drain();
    @(negedge clk);
    while (in_flight != '0) begin
      release_cycle();
      @(negedge clk);
    end
  endtask

  initial begin
    lfsr_q = 32'ha841;
    rst_n <= 1'b0;
    flush <= 1'b0;
    issue_valid <= 1'b0;
    issue_funct3 <= load_pkg::lb;
    issue_imm <= '0;
    issue_rob <= '0;
    issue_rs1_ready <= 1'b0;
    issue_rs1_v <= '0;
    issue_rs1_rob <= '0;
    for (int p = 0; p < load_pkg::cdb_ports; p++) begin
      cdb_valid[p] <= 1'b0;
      cdb_rob[p] <= '0;
      cdb_v[p] <= '0;
    end
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < n_random; i++) issue_load(2);
    drain();
    // flush with a read in flight and held entries
    issue_load(1);
    issue_load(1);
    issue_load(0);
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    repeat (load_pkg::mem_latency + 4) @(posedge clk);
    // fill the station with waiting loads
    for (int i = 0; i < n_full; i++) issue_load(1);
    repeat (4) @(posedge clk);
    drain();
    @(negedge clk);
    if (in_flight == '0 && !rd_busy) begin
      $display("TEST PASS");
      $finish;
    end else begin
      report_error("loads left in flight at the end of the test");
    end
  end

endmodule

// ==== rtl/load_unit_top.sv ====
module load_unit_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           flush,

  input  logic                           issue_valid,
  input  load_pkg::load_funct_e          issue_funct3,
  input  logic [31:0]                    issue_imm,
  input  logic [load_pkg::rob_tag_w-1:0] issue_rob,
  input  logic                           issue_rs1_ready,
  input  logic [31:0]                    issue_rs1_v,
  input  logic [load_pkg::rob_tag_w-1:0] issue_rs1_rob,
  output logic                           rs_full,

  input  logic                           cdb_valid [load_pkg::cdb_ports],
  input  logic [load_pkg::rob_tag_w-1:0] cdb_rob   [load_pkg::cdb_ports],
  input  logic [31:0]                    cdb_v     [load_pkg::cdb_ports],

  output logic                           dmem_rd,
  output logic [31:0]                    dmem_addr,
  output logic [3:0]                     dmem_rmask,
  input  logic [31:0]                    dmem_rdata,

  output logic                           res_valid,
  output logic [load_pkg::rob_tag_w-1:0] res_rob,
  output logic [31:0]                    res_v,
  output logic [31:0]                    res_addr,
  output logic [3:0]                     res_rmask
);

  logic                          req_valid;
  logic [load_pkg::rs_idx_w-1:0] req_idx;
  logic [load_pkg::rs_idx_w-1:0] exec_idx;
  load_pkg::load_funct_e         exec_funct3;
  logic                          pop;
  logic                          timer_start;
  logic                          data_ready;

  load_rs rs_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .flush           (flush),
    .issue_valid     (issue_valid),
    .issue_funct3    (issue_funct3),
    .issue_imm       (issue_imm),
    .issue_rob       (issue_rob),
    .issue_rs1_ready (issue_rs1_ready),
    .issue_rs1_v     (issue_rs1_v),
    .issue_rs1_rob   (issue_rs1_rob),
    .cdb_valid       (cdb_valid),
    .cdb_rob         (cdb_rob),
    .cdb_v           (cdb_v),
    .pop             (pop),
    .exec_idx        (exec_idx),
    .rs_full         (rs_full),
    .req_valid       (req_valid),
    .req_idx         (req_idx),
    .req_addr        (dmem_addr),
    .req_rmask       (dmem_rmask),
    .exec_funct3     (exec_funct3),
    .exec_addr       (res_addr),
    .exec_rob        (res_rob)
  );

  load_mem_ctrl ctrl_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .req_valid   (req_valid),
    .req_idx     (req_idx),
    .data_ready  (data_ready),
    .dmem_rd     (dmem_rd),
    .timer_start (timer_start),
    .exec_idx    (exec_idx),
    .pop         (pop),
    .res_valid   (res_valid)
  );

  mem_latency_timer timer_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .start      (timer_start),
    .data_ready (data_ready)
  );

  // aligner sees the entry being retired
  load_align align_i (
    .funct3 (exec_funct3),
    .addr   (res_addr),
    .rdata  (dmem_rdata),
    .value  (res_v),
    .rmask  (res_rmask)
  );

endmodule

// ==== rtl/load_align.sv ====
module load_align (
  input  load_pkg::load_funct_e funct3,
  input  logic [31:0]           addr,
  input  logic [31:0]           rdata,
  output logic [31:0]           value,
  output logic [3:0]            rmask
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  // byte lane picked by the low address bits
  assign byte_sel = rdata[{addr[1:0], 3'b000} +: 8];
  assign half_sel = addr[1] ? rdata[31:16] : rdata[15:0];

  always_comb begin
    case (funct3)
      load_pkg::lb: begin
        value = {{24{byte_sel[7]}}, byte_sel};
      end
      load_pkg::lbu: begin
        value = {24'h0, byte_sel};
      end
      load_pkg::lh: begin
        value = {{16{half_sel[15]}}, half_sel};
      end
      load_pkg::lhu: begin
        value = {16'h0, half_sel};
      end
      default: begin
        // lw passes the word through
        value = rdata;
      end
    endcase
  end

  assign rmask = load_pkg::read_mask(funct3, addr[1:0]);

endmodule

// ==== rtl/mem_latency_timer.sv ====
module mem_latency_timer (
  input  logic clk,
  input  logic rst_n,
  input  logic flush,
  input  logic start,
  output logic data_ready
);

  logic [load_pkg::timer_w-1:0] count_q;
  logic                         active_q;

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      count_q  <= '0;
      active_q <= 1'b0;
    end else if (start) begin
      // start cycle counts as the first of the latency
      count_q  <= load_pkg::mem_latency[load_pkg::timer_w-1:0] - 1'b1;
      active_q <= 1'b1;
    end else if (data_ready) begin
      active_q <= 1'b0;
    end else if (active_q) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign data_ready = active_q && (count_q == '0);

endmodule

// ==== rtl/load_mem_ctrl.sv ====
module load_mem_ctrl (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          flush,
  input  logic                          req_valid,
  input  logic [load_pkg::rs_idx_w-1:0] req_idx,
  input  logic                          data_ready,

  output logic                          dmem_rd,
  output logic                          timer_start,
  output logic [load_pkg::rs_idx_w-1:0] exec_idx,
  output logic                          pop,
  output logic                          res_valid
);

  load_pkg::ctrl_state_e         state_q;
  load_pkg::ctrl_state_e         state_d;
  logic [load_pkg::rs_idx_w-1:0] idx_q;

  always_comb begin
    state_d = state_q;
    dmem_rd = 1'b0;
    pop     = 1'b0;
    case (state_q)
      load_pkg::idle: begin
        if (req_valid && !flush) begin
          dmem_rd = 1'b1;
          state_d = load_pkg::wait_data;
        end
      end
      load_pkg::wait_data: begin
        // read data valid this cycle, retire the entry
        if (data_ready && !flush) begin
          pop     = 1'b1;
          state_d = load_pkg::idle;
        end
      end
      default: begin
        state_d = load_pkg::idle;
      end
    endcase
    if (flush) begin
      state_d = load_pkg::idle;
    end
  end

  assign timer_start = dmem_rd;
  assign res_valid   = pop;
  assign exec_idx    = idx_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= load_pkg::idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (dmem_rd) begin
      idx_q <= req_idx;
    end
  end

  // timer only runs while a read is outstanding
  a_no_data_idle: assert property (
    @(posedge clk) disable iff (!rst_n) (state_q == load_pkg::idle) |-> !data_ready
  ) else $error("data_ready seen with no read outstanding");

endmodule

// ==== rtl/load_rs.sv ====
module load_rs (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   flush,

  input  logic                                   issue_valid,
  input  load_pkg::load_funct_e                  issue_funct3,
  input  logic [31:0]                            issue_imm,
  input  logic [load_pkg::rob_tag_w-1:0]         issue_rob,
  input  logic                                   issue_rs1_ready,
  input  logic [31:0]                            issue_rs1_v,
  input  logic [load_pkg::rob_tag_w-1:0]         issue_rs1_rob,

  input  logic                                   cdb_valid [load_pkg::cdb_ports],
  input  logic [load_pkg::rob_tag_w-1:0]         cdb_rob   [load_pkg::cdb_ports],
  input  logic [31:0]                            cdb_v     [load_pkg::cdb_ports],

  input  logic                                   pop,
  input  logic [load_pkg::rs_idx_w-1:0]          exec_idx,

  output logic                                   rs_full,
  output logic                                   req_valid,
  output logic [load_pkg::rs_idx_w-1:0]          req_idx,
  output logic [31:0]                            req_addr,
  output logic [3:0]                             req_rmask,

  output load_pkg::load_funct_e                  exec_funct3,
  output logic [31:0]                            exec_addr,
  output logic [load_pkg::rob_tag_w-1:0]         exec_rob
);

  logic [load_pkg::rs_entries-1:0]  busy_q;
  logic [load_pkg::rs_entries-1:0]  ready_q;
  logic [load_pkg::rs_idx_w-1:0]    rr_ptr_q;

  load_pkg::load_funct_e            funct3_q  [load_pkg::rs_entries];
  logic [31:0]                      imm_q     [load_pkg::rs_entries];
  logic [31:0]                      rs1_v_q   [load_pkg::rs_entries];
  logic [load_pkg::rob_tag_w-1:0]   rs1_rob_q [load_pkg::rs_entries];
  logic [load_pkg::rob_tag_w-1:0]   rob_q     [load_pkg::rs_entries];

  logic [load_pkg::rs_entries-1:0]  wake;
  logic [31:0]                      wake_v    [load_pkg::rs_entries];
  logic                             issue_wake;
  logic [31:0]                      issue_wake_v;

  logic [load_pkg::rs_idx_w-1:0]    free_idx;
  logic                             issue_we;

  assign rs_full  = &busy_q;
  assign issue_we = issue_valid && !rs_full;

  // lowest free entry
  always_comb begin
    free_idx = '0;
    for (int i = load_pkg::rs_entries - 1; i >= 0; i--) begin
      if (!busy_q[i]) begin
        free_idx = i[load_pkg::rs_idx_w-1:0];
      end
    end
  end

  // cdb tag match for waiting entries and for the load being issued
  always_comb begin
    issue_wake   = 1'b0;
    issue_wake_v = '0;
    for (int i = 0; i < load_pkg::rs_entries; i++) begin
      wake[i]   = 1'b0;
      wake_v[i] = '0;
      for (int p = 0; p < load_pkg::cdb_ports; p++) begin
        if (cdb_valid[p] && cdb_rob[p] == rs1_rob_q[i]) begin
          wake[i]   = busy_q[i] && !ready_q[i];
          wake_v[i] = cdb_v[p];
        end
      end
    end
    for (int p = 0; p < load_pkg::cdb_ports; p++) begin
      if (cdb_valid[p] && cdb_rob[p] == issue_rs1_rob) begin
        issue_wake   = 1'b1;
        issue_wake_v = cdb_v[p];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      busy_q   <= '0;
      ready_q  <= '0;
      rr_ptr_q <= '0;
    end else begin
      for (int i = 0; i < load_pkg::rs_entries; i++) begin
        if (wake[i]) begin
          ready_q[i] <= 1'b1;
        end
      end
      if (issue_we) begin
        busy_q[free_idx]  <= 1'b1;
        ready_q[free_idx] <= issue_rs1_ready || issue_wake;
      end
      // popped entry is busy, so never the one being written by issue
      if (pop) begin
        busy_q[exec_idx]  <= 1'b0;
        ready_q[exec_idx] <= 1'b0;
        rr_ptr_q          <= exec_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < load_pkg::rs_entries; i++) begin
      if (wake[i]) begin
        rs1_v_q[i] <= wake_v[i];
      end
    end
    if (issue_we) begin
      funct3_q[free_idx]  <= issue_funct3;
      imm_q[free_idx]     <= issue_imm;
      rob_q[free_idx]     <= issue_rob;
      rs1_rob_q[free_idx] <= issue_rs1_rob;
      rs1_v_q[free_idx]   <= issue_rs1_ready ? issue_rs1_v : issue_wake_v;
    end
  end

  // round robin from the entry after the last pop
  always_comb begin
    logic [load_pkg::rs_idx_w-1:0] cand;
    req_valid = 1'b0;
    req_idx   = rr_ptr_q;
    for (int k = 0; k < load_pkg::rs_entries; k++) begin
      cand = rr_ptr_q + k[load_pkg::rs_idx_w-1:0];
      if (!req_valid && busy_q[cand] && ready_q[cand]) begin
        req_valid = 1'b1;
        req_idx   = cand;
      end
    end
  end

  assign req_addr  = rs1_v_q[req_idx] + imm_q[req_idx];
  assign req_rmask = load_pkg::read_mask(funct3_q[req_idx], req_addr[1:0]);

  assign exec_funct3 = funct3_q[exec_idx];
  assign exec_addr   = rs1_v_q[exec_idx] + imm_q[exec_idx];
  assign exec_rob    = rob_q[exec_idx];

  // issuer has to honour rs_full
  a_no_issue_full: assert property (
    @(posedge clk) disable iff (!rst_n) issue_valid |-> !rs_full
  ) else $error("load issued while station full");

  a_pop_busy: assert property (
    @(posedge clk) disable iff (!rst_n) pop |-> busy_q[exec_idx]
  ) else $error("pop of a free station entry");

endmodule

// ==== rtl/load_pkg.sv ====
package load_pkg;

  // station geometry
  localparam int unsigned rs_entries = 4;
  localparam int unsigned rs_idx_w = 2;

  localparam int unsigned rob_tag_w = 3;
  localparam int unsigned cdb_ports = 2;

  // fixed read latency of the data memory, in cycles
  localparam int unsigned mem_latency = 3;
  localparam int unsigned timer_w = 2;

  // rv32i load funct3 encodings
  typedef enum logic [2:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    lbu = 3'b100,
    lhu = 3'b101
  } load_funct_e;

  typedef enum logic [1:0] {
    idle      = 2'b00,
    wait_data = 2'b01
  } ctrl_state_e;

  // byte enables of a load at the given offset
  function automatic logic [3:0] read_mask(
    input load_funct_e funct3,
    input logic [1:0]  offset
  );
    logic [3:0] mask;
    case (funct3)
      lb, lbu: begin
        mask = 4'b0001 << offset;
      end
      lh, lhu: begin
        mask = 4'b0011 << offset;
      end
      lw: begin
        mask = 4'b1111;
      end
      default: begin
        mask = 4'b0000;
      end
    endcase
    return mask;
  endfunction

endpackage
